//--- verilog/hawk_cfg.svh
// widths, page geometry, slot count and read FIFO depth of the decompression path
`ifndef HAWK_CFG_SVH
`define HAWK_CFG_SVH

// AXI read port
`define HAWK_ADDR_W 32
`define HAWK_DATA_W 128

// decompressed output stream
`define HAWK_WORD_W 32
`define HAWK_PAGE_BYTES 4096
`define HAWK_PAGE_WORDS 1024

// rle beat layout, run length sits above the 32-bit value
`define HAWK_RUN_W 16

// zspage geometry
`define HAWK_SLOTS 5
`define HAWK_OFS_W 11  // offset from the 4 KB way base

// compressed beat buffer between manager and expander
`define HAWK_FIFO_DEPTH 16

`endif

//--- verilog/hawk_pkg.sv
// width typedefs, metadata and channel structs, manager states and size class table
`include "hawk_cfg.svh"

package hawk_pkg;

	typedef logic [`HAWK_ADDR_W-1:0] addr_t;
	typedef logic [`HAWK_DATA_W-1:0] beat_t;
	typedef logic [`HAWK_WORD_W-1:0] word_t;
	typedef logic [`HAWK_RUN_W-1:0] run_t;
	typedef logic [1:0] size_idx_t;   // 256, 512, 1024, 2048 bytes
	typedef logic [`HAWK_SLOTS-1:0] slot_vec_t;
	typedef logic [`HAWK_OFS_W-1:0] ofs_t;
	typedef logic [7:0] beat_cnt_t;   // beats of one compressed page
	typedef logic [$clog2(`HAWK_FIFO_DEPTH+1)-1:0] fifo_cnt_t;
	typedef logic [$clog2(`HAWK_PAGE_WORDS+1)-1:0] wcnt_t;

	// one metadata beat, iway_ptr in the lowest bits
	typedef struct packed {
		ofs_t [`HAWK_SLOTS-1:0] pg_ofs;
		slot_vec_t pg_vld;
		size_idx_t size_idx;
		addr_t nxt_way_ptr;
		addr_t iway_ptr;
	} zspg_md_t;

	typedef struct packed {
		logic arvalid;
		addr_t addr;
		logic [7:0] arlen;  // single beat bursts only
	} ar_pkt_t;

	typedef struct packed {
		logic rvalid;
		beat_t rdata;
		logic [1:0] rresp;
		logic rlast;
	} r_pkt_t;

	// metadata writeback, new_loc is the way that took the page
	typedef struct packed {
		logic valid;
		zspg_md_t md;
		addr_t new_loc;
	} zspg_upd_t;

	typedef struct packed {
		logic valid;
		addr_t way_ptr;
		size_idx_t ifl_idx;
	} tol_upd_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_REQ_MD,
		ST_WAIT_MD,
		ST_SET_FREE,
		ST_FLUSH,
		ST_SETTLE,
		ST_BURST,
		ST_DECOMP,
		ST_WB_WAIT,
		ST_PUSH_IFL,
		ST_WAIT_TBL,
		ST_DONE,
		ST_MNGR_ERR,
		ST_BUS_ERR
	} decomp_state_e;

	function automatic logic [11:0] csize_bytes(size_idx_t idx);
		case (idx)
			2'd0: csize_bytes = 12'd256;
			2'd1: csize_bytes = 12'd512;
			2'd2: csize_bytes = 12'd1024;
			default: csize_bytes = 12'd2048;
		endcase
	endfunction

endpackage

//--- verilog/hawk_decomp_mngr.sv
// decompression manager FSM: metadata walk, slot release, credit based burst read, writeback and free list push
`timescale 1ns/10ps
`include "hawk_cfg.svh"

module hawk_decomp_mngr (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 trigger,
	input  hawk_pkg::addr_t      cpage_addr,
	input  hawk_pkg::addr_t      free_way,
	output hawk_pkg::ar_pkt_t    ar,
	input  logic                 arready,
	input  hawk_pkg::r_pkt_t     r,
	output logic                 rready,
	input  logic                 fifo_full,
	input  hawk_pkg::fifo_cnt_t  fifo_free,
	output logic                 fifo_push,
	output hawk_pkg::beat_t      fifo_data,
	output logic                 flush,
	output logic                 decomp_start,
	input  logic                 decomp_done,
	output hawk_pkg::zspg_upd_t  zspg_upd,
	input  logic                 zspg_updated,
	output hawk_pkg::tol_upd_t   tol_upd,
	input  logic                 tol_ready,
	input  logic                 tbl_update_done,
	output logic                 done,
	output logic                 bus_error,
	output logic                 mngr_error,
	output logic [31:0]          page_cnt
);

	localparam int BEAT_SHIFT = $clog2(`HAWK_DATA_W / 8);
	localparam hawk_pkg::addr_t PAGE_MASK = hawk_pkg::addr_t'(`HAWK_PAGE_BYTES - 1);

	hawk_pkg::decomp_state_e state;
	hawk_pkg::addr_t cpg_q;
	hawk_pkg::addr_t free_q;
	hawk_pkg::addr_t rd_addr_q;  // next burst beat address
	hawk_pkg::zspg_md_t md_q;
	hawk_pkg::zspg_md_t md_rx;
	hawk_pkg::addr_t way_base;
	hawk_pkg::slot_vec_t clr_mask;
	hawk_pkg::beat_cnt_t page_beats;
	hawk_pkg::beat_cnt_t issue_left;
	hawk_pkg::beat_cnt_t push_left;
	hawk_pkg::fifo_cnt_t in_flight;  // issued, beat not yet pushed
	logic pp_ifl_q;
	logic r_ok;
	logic r_err;
	logic issue;

	assign md_rx = hawk_pkg::zspg_md_t'(r.rdata[$bits(hawk_pkg::zspg_md_t)-1:0]);
	assign way_base = md_q.iway_ptr & ~PAGE_MASK;
	assign page_beats = hawk_pkg::beat_cnt_t'(hawk_pkg::csize_bytes(md_q.size_idx) >> BEAT_SHIFT);

	assign rready = (state == hawk_pkg::ST_BURST) ? !fifo_full : 1'b1;
	assign r_ok = r.rvalid && rready && (r.rresp == 2'b00);
	assign r_err = r.rvalid && rready && (r.rresp != 2'b00);

	// one credit per address, a FIFO entry is held for every beat in flight
	assign issue = (state == hawk_pkg::ST_BURST) && !ar.arvalid && (issue_left != '0)
		&& (fifo_free > in_flight);

	assign fifo_push = (state == hawk_pkg::ST_BURST) && r_ok;
	assign fifo_data = r.rdata;

	assign flush = (state == hawk_pkg::ST_FLUSH);
	assign done = (state == hawk_pkg::ST_DONE);
	assign bus_error = (state == hawk_pkg::ST_BUS_ERR);
	assign mngr_error = (state == hawk_pkg::ST_MNGR_ERR);

	// first valid slot whose page sits at the requested address
	always_comb begin
		clr_mask = '0;
		for (int i = 0; i < `HAWK_SLOTS; i++) begin
			if (md_q.pg_vld[i] && (clr_mask == '0)
				&& (way_base + hawk_pkg::addr_t'(md_q.pg_ofs[i]) == cpg_q)) begin
				clr_mask[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state <= hawk_pkg::ST_IDLE;
			ar <= '0;
			decomp_start <= 1'b0;
			zspg_upd <= '0;
			tol_upd <= '0;
			issue_left <= '0;
			push_left <= '0;
			in_flight <= '0;
			pp_ifl_q <= 1'b0;
			page_cnt <= '0;
		end else begin
			if (ar.arvalid && arready)
				ar.arvalid <= 1'b0;
			case (state)
				hawk_pkg::ST_IDLE: begin
					if (trigger)
						state <= hawk_pkg::ST_REQ_MD;
				end
				hawk_pkg::ST_REQ_MD: begin
					ar.arvalid <= 1'b1;
					ar.addr <= cpg_q & ~PAGE_MASK;  // zspage header of this way
					ar.arlen <= '0;
					state <= hawk_pkg::ST_WAIT_MD;
				end
				hawk_pkg::ST_WAIT_MD: begin
					if (r_err) begin
						state <= hawk_pkg::ST_BUS_ERR;
					end else if (r_ok) begin
						// ar.addr still holds the record address just read
						if (md_rx.iway_ptr == ar.addr) begin
							pp_ifl_q <= &md_rx.pg_vld;
							state <= hawk_pkg::ST_SET_FREE;
						end else begin
							ar.arvalid <= 1'b1;
							ar.addr <= md_rx.nxt_way_ptr;
						end
					end
				end
				hawk_pkg::ST_SET_FREE: begin
					if (|clr_mask)
						state <= hawk_pkg::ST_FLUSH;
					else
						state <= hawk_pkg::ST_MNGR_ERR;
				end
				hawk_pkg::ST_FLUSH: state <= hawk_pkg::ST_SETTLE;
				hawk_pkg::ST_SETTLE: begin
					issue_left <= page_beats;
					push_left <= page_beats;
					in_flight <= '0;
					state <= hawk_pkg::ST_BURST;
				end
				hawk_pkg::ST_BURST: begin
					if (r_err) begin
						state <= hawk_pkg::ST_BUS_ERR;
					end else begin
						if (issue) begin
							ar.arvalid <= 1'b1;
							ar.addr <= rd_addr_q;
							issue_left <= issue_left - 1'b1;
						end
						in_flight <= in_flight + hawk_pkg::fifo_cnt_t'(issue)
							- hawk_pkg::fifo_cnt_t'(fifo_push);
						if (fifo_push) begin
							push_left <= push_left - 1'b1;
							if (push_left == hawk_pkg::beat_cnt_t'(1)) begin
								decomp_start <= 1'b1;  // last beat is in the FIFO
								state <= hawk_pkg::ST_DECOMP;
							end
						end
					end
				end
				hawk_pkg::ST_DECOMP: begin
					if (decomp_done) begin
						decomp_start <= 1'b0;
						zspg_upd.valid <= 1'b1;
						zspg_upd.md <= md_q;
						zspg_upd.new_loc <= free_q;
						state <= hawk_pkg::ST_WB_WAIT;
					end
				end
				hawk_pkg::ST_WB_WAIT: begin
					if (zspg_updated) begin
						zspg_upd.valid <= 1'b0;
						if (pp_ifl_q) begin
							// zspage was full, it goes back on the irregular free list
							tol_upd.valid <= 1'b1;
							tol_upd.way_ptr <= md_q.iway_ptr;
							tol_upd.ifl_idx <= md_q.size_idx;
							state <= hawk_pkg::ST_PUSH_IFL;
						end else begin
							state <= hawk_pkg::ST_DONE;
						end
					end
				end
				hawk_pkg::ST_PUSH_IFL: begin
					if (tol_ready) begin
						tol_upd.valid <= 1'b0;
						if (tbl_update_done)
							state <= hawk_pkg::ST_DONE;
						else
							state <= hawk_pkg::ST_WAIT_TBL;
					end
				end
				hawk_pkg::ST_WAIT_TBL: begin
					if (tbl_update_done)
						state <= hawk_pkg::ST_DONE;
				end
				hawk_pkg::ST_DONE: begin
					page_cnt <= page_cnt + 32'd1;
					state <= hawk_pkg::ST_IDLE;
				end
				default: state <= state;  // error states are sticky
			endcase
		end
	end

	// request payload and working copy of the record
	always_ff @(posedge clk_i) begin
		if (state == hawk_pkg::ST_IDLE && trigger) begin
			cpg_q <= cpage_addr;
			free_q <= free_way;
		end
		if (state == hawk_pkg::ST_WAIT_MD && r_ok)
			md_q <= md_rx;
		if (state == hawk_pkg::ST_SET_FREE)
			md_q.pg_vld <= md_q.pg_vld & ~clr_mask;  // release the slot
		if (state == hawk_pkg::ST_SETTLE)
			rd_addr_q <= cpg_q;
		else if (issue)
			rd_addr_q <= rd_addr_q + hawk_pkg::addr_t'(`HAWK_DATA_W / 8);
	end

	a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		ar.arvalid && !arready |=> ar.arvalid && $stable(ar.addr));

	a_rlast: assert property (@(posedge clk_i) disable iff (!rst_ni)
		r.rvalid |-> r.rlast);

	// beats in flight always fit the room left in the FIFO
	a_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		state == hawk_pkg::ST_BURST |-> in_flight <= fifo_free);

endmodule

//--- verilog/hawk_rd_fifo.sv
// synchronous read beat FIFO with flush, occupancy and free count
`timescale 1ns/10ps
`include "hawk_cfg.svh"

module hawk_rd_fifo (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 flush,
	input  logic                 push,
	input  hawk_pkg::beat_t      push_data,
	input  logic                 pop,
	output hawk_pkg::beat_t      pop_data,
	output logic                 full,
	output logic                 empty,
	output hawk_pkg::fifo_cnt_t  free
);

	localparam int PTR_W = $clog2(`HAWK_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`HAWK_FIFO_DEPTH - 1);

	hawk_pkg::beat_t mem [`HAWK_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	hawk_pkg::fifo_cnt_t count;
	logic do_push;
	logic do_pop;

	assign full = (count == hawk_pkg::fifo_cnt_t'(`HAWK_FIFO_DEPTH));
	assign empty = (count == '0);
	assign free = hawk_pkg::fifo_cnt_t'(`HAWK_FIFO_DEPTH) - count;
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign pop_data = mem[rd_ptr];  // head is visible before the pop

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + hawk_pkg::fifo_cnt_t'(do_push) - hawk_pkg::fifo_cnt_t'(do_pop);
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) push |-> !full);
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) pop |-> !empty);

endmodule

//--- verilog/hawk_rle_expander.sv
// run length expander from FIFO beats to a one page stream of 32-bit words
`timescale 1ns/10ps
`include "hawk_cfg.svh"

module hawk_rle_expander (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             start,
	input  logic             flush,
	input  logic             fifo_empty,
	input  hawk_pkg::beat_t  fifo_data,
	input  logic             out_ready,
	output logic             fifo_pop,
	output logic             out_valid,
	output hawk_pkg::word_t  out_data,
	output logic             decomp_done
);

	localparam int RUN_LSB = `HAWK_WORD_W;
	localparam hawk_pkg::wcnt_t LAST_WORD = hawk_pkg::wcnt_t'(`HAWK_PAGE_WORDS - 1);

	hawk_pkg::run_t run_left;
	hawk_pkg::run_t beat_run;
	hawk_pkg::wcnt_t wcnt;  // words emitted for this page
	hawk_pkg::word_t val_q;
	logic page_full;
	logic done_sent;

	assign beat_run = fifo_data[RUN_LSB +: `HAWK_RUN_W];
	assign page_full = (wcnt == hawk_pkg::wcnt_t'(`HAWK_PAGE_WORDS));

	// beats past the page end are still drained so the burst can finish
	assign fifo_pop = (run_left == '0) && !fifo_empty;
	assign out_valid = (run_left != '0);
	assign out_data = val_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			run_left <= '0;
			wcnt <= '0;
			done_sent <= 1'b0;
			decomp_done <= 1'b0;
		end else if (flush) begin
			run_left <= '0;
			wcnt <= '0;
			done_sent <= 1'b0;
			decomp_done <= 1'b0;
		end else begin
			decomp_done <= 1'b0;
			if (fifo_pop && !page_full) begin
				run_left <= beat_run;
			end else if (out_valid && out_ready) begin
				wcnt <= wcnt + 1'b1;
				// rest of the run is dropped at the page end
				run_left <= (wcnt == LAST_WORD) ? '0 : run_left - 1'b1;
			end
			if (start && page_full && !done_sent) begin
				decomp_done <= 1'b1;
				done_sent <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (fifo_pop)
			val_q <= fifo_data[`HAWK_WORD_W-1:0];
	end

	a_run_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fifo_pop |-> beat_run != '0);

endmodule

//--- verilog/hawk_decomp_top.sv
// decompression path top: manager, read FIFO and run length expander
`timescale 1ns/10ps

module hawk_decomp_top (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 trigger,
	input  hawk_pkg::addr_t      cpage_addr,
	input  hawk_pkg::addr_t      free_way,
	output hawk_pkg::ar_pkt_t    ar,
	input  logic                 arready,
	input  hawk_pkg::r_pkt_t     r,
	output logic                 rready,
	output logic                 out_valid,
	output hawk_pkg::word_t      out_data,
	input  logic                 out_ready,
	output hawk_pkg::zspg_upd_t  zspg_upd,
	input  logic                 zspg_updated,
	output hawk_pkg::tol_upd_t   tol_upd,
	input  logic                 tol_ready,
	input  logic                 tbl_update_done,
	output logic                 done,
	output logic                 bus_error,
	output logic                 mngr_error,
	output logic [31:0]          page_cnt
);

	logic fifo_full;
	logic fifo_empty;
	hawk_pkg::fifo_cnt_t fifo_free;
	logic fifo_push;
	hawk_pkg::beat_t fifo_push_data;
	logic fifo_pop;
	hawk_pkg::beat_t fifo_pop_data;
	logic flush;
	logic decomp_start;
	logic decomp_done;

	hawk_decomp_mngr u_mngr (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.trigger(trigger), .cpage_addr(cpage_addr), .free_way(free_way),
		.ar(ar), .arready(arready), .r(r), .rready(rready),
		.fifo_full(fifo_full), .fifo_free(fifo_free),
		.fifo_push(fifo_push), .fifo_data(fifo_push_data),
		.flush(flush), .decomp_start(decomp_start), .decomp_done(decomp_done),
		.zspg_upd(zspg_upd), .zspg_updated(zspg_updated),
		.tol_upd(tol_upd), .tol_ready(tol_ready), .tbl_update_done(tbl_update_done),
		.done(done), .bus_error(bus_error), .mngr_error(mngr_error), .page_cnt(page_cnt)
	);

	hawk_rd_fifo u_fifo (
		.clk_i(clk_i), .rst_ni(rst_ni), .flush(flush),
		.push(fifo_push), .push_data(fifo_push_data),
		.pop(fifo_pop), .pop_data(fifo_pop_data),
		.full(fifo_full), .empty(fifo_empty), .free(fifo_free)
	);

	hawk_rle_expander u_rle (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.start(decomp_start), .flush(flush),
		.fifo_empty(fifo_empty), .fifo_data(fifo_pop_data), .fifo_pop(fifo_pop),
		.out_ready(out_ready), .out_valid(out_valid), .out_data(out_data),
		.decomp_done(decomp_done)
	);

endmodule

//--- verif/tb_hawk_tasks.svh
// directed test tasks, xorshift generator, check helpers and memory image builder
`ifndef TB_HAWK_TASKS_SVH
`define TB_HAWK_TASKS_SVH

function automatic logic [31:0] xorshift(logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic logic [31:0] tst_rand();
	rng_tst = xorshift(rng_tst);
	return rng_tst;
endfunction

function automatic hawk_pkg::beat_t read_mem(hawk_pkg::addr_t a);
	if (mem.exists(a))
		return mem[a];
	return {4{a ^ 32'h3c5a_96e1}};  // unwritten beats follow the address
endfunction

task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] got);
	checks++;
	assert (exp === got) else begin
		errors++;
		$display("FAIL %s expected %h got %h", name, exp, got);
	end
endtask

task automatic check_true(input bit cond, input string msg);
	checks++;
	assert (cond) else begin
		errors++;
		$display("error: %s", msg);
	end
endtask

task automatic apply_reset();
	rst_ni <= 1'b0;
	repeat (3) @(posedge clk_i);
	rst_ni <= 1'b1;
	@(posedge clk_i);
endtask

// metadata record, optional chain header, rle beats and expected words
task automatic build_image(input int id, input hawk_pkg::size_idx_t sz, input bit full,
	input bit chain);
	hawk_pkg::zspg_md_t md;
	hawk_pkg::zspg_md_t hdr;
	hawk_pkg::addr_t wb;
	hawk_pkg::word_t v;
	hawk_pkg::run_t run;
	int slot;
	int nb;
	wb = 32'h1000_0000 + (id << 16);
	slot = int'(tst_rand() % 5);
	md = '0;
	for (int i = 0; i < `HAWK_SLOTS; i++)
		md.pg_ofs[i] = hawk_pkg::ofs_t'(32'h40 + i * 32'h100);
	if (full)
		md.pg_vld = '1;
	else
		md.pg_vld = (5'(tst_rand()) | (5'b1 << slot)) & ~(5'b1 << ((slot + 1) % 5));
	md.size_idx = sz;
	cur_rec = chain ? wb + 32'h20 : wb;
	md.iway_ptr = cur_rec;
	cur_cpg = wb + 32'(md.pg_ofs[slot]);
	cur_free = 32'h8000_0000 + (id << 12);
	mem.delete();
	exp_ar.delete();
	exp_q.delete();
	if (chain) begin
		hdr = md;
		hdr.iway_ptr = 32'hdead_0000 ^ wb;  // another way's header
		hdr.nxt_way_ptr = cur_rec;
		mem[wb] = hawk_pkg::beat_t'(hdr);
		exp_ar.push_back(wb);
	end
	mem[cur_rec] = hawk_pkg::beat_t'(md);
	exp_ar.push_back(cur_rec);
	nb = (256 << sz) / 16;
	for (int b = 0; b < nb; b++) begin
		v = tst_rand();
		run = hawk_pkg::run_t'(1024 / nb + tst_rand() % 4);
		mem[cur_cpg + 16 * b] = {80'b0, run, v};
		exp_ar.push_back(cur_cpg + 16 * b);
		for (int k = 0; k < run; k++)
			if (exp_q.size() < `HAWK_PAGE_WORDS)
				exp_q.push_back(v);
	end
	exp_md = md;
	exp_md.pg_vld[slot] = 1'b0;
endtask

task automatic trigger_page();
	@(posedge clk_i);
	trigger <= 1'b1;
	cpage_addr <= cur_cpg;
	free_way <= cur_free;
	@(posedge clk_i);
	trigger <= 1'b0;
endtask

task automatic run_page(input int id, input hawk_pkg::size_idx_t sz, input bit full,
	input bit chain, input bit bp);
	int n;
	int d0;
	int t0;
	logic [31:0] pc0;
	build_image(id, sz, full, chain);
	ar_log.delete();
	d0 = done_cnt;
	t0 = tol_cnt;
	pc0 = page_cnt;
	bp_on = bp;
	trigger_page();
	n = 0;
	while (!zspg_upd.valid && n < TMO) begin
		@(posedge clk_i);
		n++;
	end
	check_true(n < TMO, "timed out waiting for the metadata writeback");
	check_true(exp_q.size() == 0, "page ended before all expected words came out");
	compare("zspg_upd.md", exp_md, zspg_upd.md);
	compare("zspg_upd.new_loc", cur_free, zspg_upd.new_loc);
	zspg_updated <= 1'b1;
	@(posedge clk_i);
	zspg_updated <= 1'b0;
	if (full) begin
		n = 0;
		while (!tol_upd.valid && n < TMO) begin
			@(posedge clk_i);
			n++;
		end
		check_true(n < TMO, "timed out waiting for the free list push");
		compare("tol_upd.way_ptr", cur_rec, tol_upd.way_ptr);
		compare("tol_upd.ifl_idx", sz, tol_upd.ifl_idx);
		tol_ready <= 1'b1;
		@(posedge clk_i);
		tol_ready <= 1'b0;
		repeat (6) @(posedge clk_i);
		check_true(done_cnt == d0, "done came before the table update");
		tbl_update_done <= 1'b1;
		@(posedge clk_i);
		tbl_update_done <= 1'b0;
	end
	n = 0;
	while (!done && n < TMO) begin
		@(posedge clk_i);
		n++;
	end
	check_true(n < TMO, "timed out waiting for done");
	@(posedge clk_i);
	compare("page_cnt", pc0 + 1, page_cnt);
	if (!full)
		check_true(tol_cnt == t0, "free list push raised for a zspage that was not full");
	compare("ar transfers", exp_ar.size(), ar_log.size());
	for (int i = 0; i < exp_ar.size() && i < ar_log.size(); i++)
		compare("ar.addr", exp_ar[i], ar_log[i]);
	bp_on = 0;
endtask

task automatic error_tests();
	int n;
	int d0;
	// slave error on the fourth compressed beat
	build_image(10, 2'd0, 0, 0);
	chk_words = 0;
	err_addr = cur_cpg + 32'h30;
	err_on = 1;
	d0 = done_cnt;
	trigger_page();
	n = 0;
	while (!bus_error && n < TMO) begin
		@(posedge clk_i);
		n++;
	end
	check_true(n < TMO, "bus_error did not rise on an error response");
	repeat (20) @(posedge clk_i);
	check_true(bus_error && done_cnt == d0, "bus_error not sticky or done pulsed");
	err_on = 0;
	apply_reset();
	// record without a slot for the page
	build_image(11, 2'd1, 0, 0);
	mem[cur_rec] = hawk_pkg::beat_t'(exp_md);
	d0 = done_cnt;
	trigger_page();
	n = 0;
	while (!mngr_error && n < TMO) begin
		@(posedge clk_i);
		n++;
	end
	check_true(n < TMO, "mngr_error did not rise on an unmatched record");
	repeat (10) @(posedge clk_i);
	check_true(mngr_error && done_cnt == d0, "mngr_error not sticky or done pulsed");
	apply_reset();
	chk_words = 1;
	run_page(12, 2'd1, 0, 0, 0);
endtask

`endif

//--- verif/tb_hawk_decomp.sv
// testbench top: clock, reset, DUT, AXI read responder, stream monitor, watchdog and result line
`timescale 1ns/10ps
`include "hawk_cfg.svh"

module tb_hawk_decomp;

	localparam int TMO = 6000;          // per wait, cycles
	localparam int WD_CYCLES = 10 * 2000;  // ten pages with stalls

	logic clk_i;
	logic rst_ni;
	logic trigger;
	hawk_pkg::addr_t cpage_addr;
	hawk_pkg::addr_t free_way;
	hawk_pkg::ar_pkt_t ar;
	logic arready;
	hawk_pkg::r_pkt_t r;
	logic rready;
	logic out_valid;
	hawk_pkg::word_t out_data;
	logic out_ready;
	hawk_pkg::zspg_upd_t zspg_upd;
	logic zspg_updated;
	hawk_pkg::tol_upd_t tol_upd;
	logic tol_ready;
	logic tbl_update_done;
	logic done;
	logic bus_error;
	logic mngr_error;
	logic [31:0] page_cnt;

	hawk_pkg::beat_t mem [hawk_pkg::addr_t];  // sparse memory image
	hawk_pkg::addr_t rq[$];      // accepted addresses waiting for a beat
	hawk_pkg::addr_t ar_log[$];
	hawk_pkg::addr_t exp_ar[$];
	hawk_pkg::word_t exp_q[$];
	hawk_pkg::zspg_md_t exp_md;
	hawk_pkg::addr_t cur_cpg;
	hawk_pkg::addr_t cur_rec;
	hawk_pkg::addr_t cur_free;
	hawk_pkg::addr_t err_addr;
	logic [31:0] rng_tst;
	logic [31:0] rng_rsp;
	logic [31:0] rng_bp;
	int dly;
	int errors;
	int checks;
	int done_cnt;
	int tol_cnt;
	bit err_on;
	bit bp_on;
	bit chk_words;

	hawk_decomp_top DUT (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.trigger(trigger), .cpage_addr(cpage_addr), .free_way(free_way),
		.ar(ar), .arready(arready), .r(r), .rready(rready),
		.out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
		.zspg_upd(zspg_upd), .zspg_updated(zspg_updated),
		.tol_upd(tol_upd), .tol_ready(tol_ready), .tbl_update_done(tbl_update_done),
		.done(done), .bus_error(bus_error), .mngr_error(mngr_error), .page_cnt(page_cnt)
	);

	`include "tb_hawk_tasks.svh"

	always #2 clk_i = ~clk_i;

	// one R beat per accepted address, 0 to 3 cycles later
	always @(posedge clk_i) begin
		if (!rst_ni) begin
			r <= '0;
			rq.delete();
			dly = 0;
		end else begin
			if (ar.arvalid && arready) begin
				rq.push_back(ar.addr);
				ar_log.push_back(ar.addr);
				compare("ar.arlen", 128'h0, ar.arlen);  // single beat bursts only
			end
			if (!(r.rvalid && !rready)) begin
				r.rvalid <= 1'b0;
				if (rq.size() != 0) begin
					if (dly == 0) begin
						r.rvalid <= 1'b1;
						r.rdata <= read_mem(rq[0]);
						r.rresp <= (err_on && rq[0] == err_addr) ? 2'b10 : 2'b00;
						r.rlast <= 1'b1;
						void'(rq.pop_front());
						rng_rsp = xorshift(rng_rsp);
						dly = int'(rng_rsp[1:0]);
					end else begin
						dly = dly - 1;
					end
				end
			end
		end
	end

	// random stalls on the output stream and the address channel
	always @(posedge clk_i) begin
		rng_bp = xorshift(rng_bp);
		out_ready <= bp_on ? (rng_bp[1:0] != 2'b00) : 1'b1;
		arready <= bp_on ? (rng_bp[2] | rng_bp[3]) : 1'b1;
	end

	always @(posedge clk_i) begin
		if (rst_ni) begin
			if (out_valid && out_ready && chk_words) begin
				if (exp_q.size() == 0)
					check_true(1'b0, "word emitted past the end of the page");
				else
					compare("out_data", exp_q.pop_front(), out_data);
			end
			if (done)
				done_cnt++;
			if (tol_upd.valid)
				tol_cnt++;
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, errors so far %0d", WD_CYCLES, errors);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clk_i = 1'b0;
		rst_ni = 1'b0;
		trigger = 1'b0;
		cpage_addr = '0;
		free_way = '0;
		arready = 1'b1;
		r = '0;
		out_ready = 1'b1;
		zspg_updated = 1'b0;
		tol_ready = 1'b0;
		tbl_update_done = 1'b0;
		rng_tst = 32'h60ba_feb3;
		rng_rsp = xorshift(32'h60ba_feb3);
		rng_bp = xorshift(xorshift(32'h60ba_feb3));
		err_on = 0;
		bp_on = 0;
		chk_words = 1;
		apply_reset();
		run_page(1, 2'd1, 0, 0, 0);  // direct hit
		run_page(2, 2'd2, 0, 1, 0);  // chained record
		run_page(3, 2'd3, 1, 0, 0);  // full zspage
		for (int s = 0; s < 4; s++)
			run_page(4 + s, hawk_pkg::size_idx_t'(s), 0, s[0], 1);
		error_tests();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verilog
+incdir+verif
verilog/hawk_pkg.sv
verilog/hawk_decomp_mngr.sv
verilog/hawk_rd_fifo.sv
verilog/hawk_rle_expander.sv
verilog/hawk_decomp_top.sv
verif/tb_hawk_decomp.sv

//--- Makefile
SIM := obj_dir/Vtb_hawk_decomp
SRCS := flist.f $(wildcard verilog/*.sv verilog/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_hawk_decomp -f flist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
